// ==== include/soc_macros.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus widths and slot map; slot offsets are word addresses of SOC_SLOT_SHIFT bits.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus.
`define SOC_ARCH_BITS 32
`define SOC_ADDR_BITS 30
`define SOC_SEL_BITS 4

// address map.
`define SOC_SLOT_SHIFT 10
`define SOC_SLOT_COUNT 4
`define SOC_DEV_COUNT 3

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// peripherals.
`define SOC_GPIO_COUNT 8
`define SOC_RST_CNTR_BITS 4
`define SOC_INT_SRC_COUNT 2

`endif

// ==== src/soc_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// encodings are fixed; slot_t and int_src_t values double as array indices.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package soc_pkg;

	typedef enum logic [1:0] {
		pi1_noop = 2'b00,
		pi1_wrop = 2'b01,
		pi1_rdop = 2'b10,
		pi1_rwop = 2'b11 // returns the old word, writes the new one.
	} pi1_op_t;

	typedef enum logic [1:0] {
		slot_devtbl  = 2'd0,
		slot_gpio    = 2'd1,
		slot_intctrl = 2'd2,
		slot_invalid = 2'd3
	} slot_t;

	typedef enum logic {rt_idle, rt_wait} router_state_t;

	typedef enum logic [1:0] {
		rst_none     = 2'd0,
		rst_warm     = 2'd1,
		rst_poweroff = 2'd2
	} rst_cmd_t;

	typedef enum logic {int_src_gpio = 1'b0, int_src_ext = 1'b1} int_src_t;

endpackage

// ==== src/reset_seq.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stretches rst_p by 15 cycles; power-off holds reset until the next rst_p.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "soc_macros.svh"

module reset_seq
	import soc_pkg::*;
(
	input  logic     clk100mhz,
	input  logic     rst_p,
	input  rst_cmd_t rst_cmd_i,
	output logic     sys_rst_o
);

	logic [`SOC_RST_CNTR_BITS-1:0] cntr_q;
	logic                          busy_q; // high while the counter still runs.
	logic                          off_q;  // power-off latch.

	// a warm command is handled like one cycle of rst_p.
	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			cntr_q <= '1;
			busy_q <= 1'b1;
			off_q  <= 1'b0;
		end else begin
			if (rst_cmd_i == rst_poweroff)
				off_q <= 1'b1;
			if (rst_cmd_i == rst_warm) begin
				cntr_q <= '1;
				busy_q <= 1'b1;
			end else begin
				busy_q <= (cntr_q != '0);
				if (cntr_q != '0)
					cntr_q <= cntr_q - 1'b1;
			end
		end
	end

	assign sys_rst_o = rst_p | busy_q | off_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	a_rst_follows_rst_p: assert property (
		@(posedge clk100mhz) $past(rst_p) |-> sys_rst_o
	);

endmodule

// ==== src/pi1_router.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one transfer in flight, 2 cycles minimum; addresses above slot 3 go to the invalid slot.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "soc_macros.svh"

module pi1_router
	import soc_pkg::*;
(
	input  logic                       clk100mhz,
	input  logic                       sys_rst_i,
	input  pi1_op_t                    m_op_i,
	input  logic [`SOC_ADDR_BITS-1:0]  m_addr_i,
	input  logic [`SOC_ARCH_BITS-1:0]  m_data_i,
	input  logic [`SOC_SEL_BITS-1:0]   m_sel_i,
	output logic [`SOC_ARCH_BITS-1:0]  m_data_o,
	output logic                       m_rdy_o,
	output pi1_op_t                    s_op_o [`SOC_DEV_COUNT],
	output logic [`SOC_SLOT_SHIFT-1:0] s_addr_o,
	output logic [`SOC_ARCH_BITS-1:0]  s_data_o,
	output logic [`SOC_SEL_BITS-1:0]   s_sel_o,
	input  logic [`SOC_ARCH_BITS-1:0]  s_data_i [`SOC_DEV_COUNT],
	input  logic [`SOC_DEV_COUNT-1:0]  s_rdy_i
);

	localparam int SLOT_BITS = $clog2(`SOC_SLOT_COUNT);
	localparam int SLOT_TOP  = `SOC_SLOT_SHIFT + SLOT_BITS;

	router_state_t                state_q;
	pi1_op_t                      op_q;
	slot_t                        slot_q;
	slot_t                        req_slot;
	logic [`SOC_SLOT_SHIFT-1:0]   addr_q;
	logic [`SOC_ARCH_BITS-1:0]    wdata_q;
	logic [`SOC_SEL_BITS-1:0]     sel_q;
	logic [`SOC_ARCH_BITS-1:0]    rdata_q;
	logic                         rdy_q;
	logic [`SOC_ARCH_BITS-1:0]    sel_data;
	logic                         sel_rdy;
	logic                         accept;
	logic                         reply;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		req_slot = slot_t'(m_addr_i[`SOC_SLOT_SHIFT +: SLOT_BITS]);
		if (|m_addr_i[`SOC_ADDR_BITS-1:SLOT_TOP])
			req_slot = slot_invalid; // outside the decoded map.
	end

	always_comb begin
		sel_rdy  = 1'b1; // invalid slot answers at once.
		sel_data = '0;
		case (slot_q)
			slot_devtbl, slot_gpio, slot_intctrl: begin
				sel_rdy  = s_rdy_i[slot_q];
				sel_data = s_data_i[slot_q];
			end
			default: ;
		endcase
	end

	assign accept = (state_q == rt_idle) && (m_op_i != pi1_noop);
	assign reply  = (state_q == rt_wait) && (op_q != pi1_noop) && sel_rdy;

	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i) begin
			state_q <= rt_idle;
			op_q    <= pi1_noop;
			slot_q  <= slot_invalid;
			rdy_q   <= 1'b0;
		end else begin
			case (state_q)
				rt_idle: if (accept) begin
					state_q <= rt_wait;
					op_q    <= m_op_i;
					slot_q  <= req_slot;
				end
				rt_wait: begin
					if (rdy_q) begin
						rdy_q   <= 1'b0; // master saw m_rdy_o.
						state_q <= rt_idle;
					end else if (reply) begin
						op_q  <= pi1_noop;
						rdy_q <= 1'b1;
					end
				end
				default: state_q <= rt_idle;
			endcase
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (accept) begin
			addr_q  <= m_addr_i[`SOC_SLOT_SHIFT-1:0];
			wdata_q <= m_data_i;
			sel_q   <= m_sel_i;
		end
		if (reply)
			rdata_q <= sel_data;
	end

	always_comb begin
		for (int i = 0; i < `SOC_DEV_COUNT; i++)
			s_op_o[i] = (int'(slot_q) == i) ? op_q : pi1_noop;
	end

	assign s_addr_o = addr_q;
	assign s_data_o = wdata_q;
	assign s_sel_o  = sel_q;
	assign m_data_o = rdata_q;
	assign m_rdy_o  = rdy_q;

	a_no_rdy_in_idle: assert property (
		@(posedge clk100mhz) (state_q == rt_idle) |-> !m_rdy_o
	);

endmodule

// ==== src/dev_table.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// read-only rows; only a write of byte 0 of row 0 issues a reset command.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "soc_macros.svh"

module dev_table
	import soc_pkg::*;
(
	input  logic                       clk100mhz,
	input  logic                       sys_rst_i,
	input  pi1_op_t                    s_op_i,
	input  logic [`SOC_SLOT_SHIFT-1:0] s_addr_i,
	input  logic [`SOC_ARCH_BITS-1:0]  s_data_i,
	input  logic [`SOC_SEL_BITS-1:0]   s_sel_i,
	output logic [`SOC_ARCH_BITS-1:0]  s_data_o,
	output logic                       s_rdy_o,
	output rst_cmd_t                   rst_cmd_o
);

	localparam logic [`SOC_ARCH_BITS-1:0]  DEV_COUNT_WORD = `SOC_DEV_COUNT;
	localparam logic [`SOC_SLOT_SHIFT-1:0] LAST_ROW       = `SOC_DEV_COUNT;
	localparam logic [15:0]                SLOT_WORDS     = 16'(1 << `SOC_SLOT_SHIFT);

	rst_cmd_t rst_cmd_q;
	logic     wr_row0;

	assign s_rdy_o = (s_op_i != pi1_noop);
	assign wr_row0 = ((s_op_i == pi1_wrop) || (s_op_i == pi1_rwop)) &&
		(s_addr_i == '0) && s_sel_i[0];

	// row n describes slot n-1.
	always_comb begin
		s_data_o = '0;
		if (s_addr_i == '0)
			s_data_o = DEV_COUNT_WORD;
		else if (s_addr_i <= LAST_ROW)
			s_data_o = {16'(s_addr_i - 1'b1), SLOT_WORDS};
	end

	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i) begin
			rst_cmd_q <= rst_none;
		end else begin
			rst_cmd_q <= rst_none; // one cycle pulse.
			if (wr_row0) begin
				case (rst_cmd_t'(s_data_i[1:0]))
					rst_warm, rst_poweroff: rst_cmd_q <= rst_cmd_t'(s_data_i[1:0]);
					default: ;
				endcase
			end
		end
	end

	assign rst_cmd_o = rst_cmd_q;

endmodule

// ==== src/gpio_port.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// inputs pass a 2-flop synchronizer; registers are written through byte 0 only.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "soc_macros.svh"

module gpio_port
	import soc_pkg::*;
(
	input  logic                       clk100mhz,
	input  logic                       sys_rst_i,
	input  pi1_op_t                    s_op_i,
	input  logic [`SOC_SLOT_SHIFT-1:0] s_addr_i,
	input  logic [`SOC_ARCH_BITS-1:0]  s_data_i,
	input  logic [`SOC_SEL_BITS-1:0]   s_sel_i,
	output logic [`SOC_ARCH_BITS-1:0]  s_data_o,
	output logic                       s_rdy_o,
	input  logic [`SOC_GPIO_COUNT-1:0] gp_i,
	output logic [`SOC_GPIO_COUNT-1:0] gp_o,
	output logic                       int_req_o,
	input  logic                       int_rdy_i
);

	localparam int PAD = `SOC_ARCH_BITS - `SOC_GPIO_COUNT;

	logic [`SOC_GPIO_COUNT-1:0] sync1_q;
	logic [`SOC_GPIO_COUNT-1:0] sync2_q;
	logic [`SOC_GPIO_COUNT-1:0] prev_q;
	logic [`SOC_GPIO_COUNT-1:0] out_q;
	logic [`SOC_GPIO_COUNT-1:0] mask_q;
	logic                       req_q;
	logic                       wr;
	logic                       change;

	assign s_rdy_o = (s_op_i != pi1_noop);
	assign wr      = ((s_op_i == pi1_wrop) || (s_op_i == pi1_rwop)) && s_sel_i[0];
	assign change  = |((sync2_q ^ prev_q) & mask_q);

	always_ff @(posedge clk100mhz) begin
		sync1_q <= gp_i;
		sync2_q <= sync1_q;
		prev_q  <= sync2_q;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i) begin
			out_q  <= '0;
			mask_q <= '0;
			req_q  <= 1'b0;
		end else begin
			if (wr && (s_addr_i == 'd1))
				out_q <= s_data_i[`SOC_GPIO_COUNT-1:0];
			if (wr && (s_addr_i == 'd2))
				mask_q <= s_data_i[`SOC_GPIO_COUNT-1:0];
			if (change)
				req_q <= 1'b1; // a new change outranks the ack.
			else if (int_rdy_i)
				req_q <= 1'b0;
		end
	end

	always_comb begin
		case (s_addr_i)
			'd0:     s_data_o = {{PAD{1'b0}}, sync2_q};
			'd1:     s_data_o = {{PAD{1'b0}}, out_q};
			'd2:     s_data_o = {{PAD{1'b0}}, mask_q};
			default: s_data_o = '0;
		endcase
	end

	assign gp_o      = out_q;
	assign int_req_o = req_q;

endmodule

// ==== src/int_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one destination; a source must drop req on its rdy pulse.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "soc_macros.svh"

module int_ctrl
	import soc_pkg::*;
(
	input  logic                          clk100mhz,
	input  logic                          sys_rst_i,
	input  pi1_op_t                       s_op_i,
	input  logic [`SOC_SLOT_SHIFT-1:0]    s_addr_i,
	input  logic [`SOC_ARCH_BITS-1:0]     s_data_i,
	input  logic [`SOC_SEL_BITS-1:0]      s_sel_i,
	output logic [`SOC_ARCH_BITS-1:0]     s_data_o,
	output logic                          s_rdy_o,
	input  logic [`SOC_INT_SRC_COUNT-1:0] src_req_i,
	output logic [`SOC_INT_SRC_COUNT-1:0] src_rdy_o,
	output logic                          irq_o,
	input  logic                          irq_ack_i
);

	localparam int PAD = `SOC_ARCH_BITS - `SOC_INT_SRC_COUNT;

	logic [`SOC_INT_SRC_COUNT-1:0] en_q;
	logic [`SOC_INT_SRC_COUNT-1:0] rdy_q;
	logic [`SOC_INT_SRC_COUNT-1:0] pending;
	logic                          irq_q;
	int_src_t                      cur_q;
	int_src_t                      last_q;
	int_src_t                      pick;
	logic                          wr_en;

	assign s_rdy_o = (s_op_i != pi1_noop);
	assign wr_en   = ((s_op_i == pi1_wrop) || (s_op_i == pi1_rwop)) &&
		(s_addr_i == 'd1) && s_sel_i[0];

	// the source just served still holds req during its rdy cycle.
	always_comb begin
		pending = src_req_i & en_q & ~rdy_q;
		pick    = int_src_gpio;
		for (int i = `SOC_INT_SRC_COUNT - 1; i >= 0; i--)
			if (pending[i])
				pick = int_src_t'(i); // lowest index wins.
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i) begin
			irq_q  <= 1'b0;
			rdy_q  <= '0;
			cur_q  <= int_src_gpio;
			last_q <= int_src_gpio;
			en_q   <= '1;
		end else begin
			rdy_q <= '0;
			if (!irq_q) begin
				if (|pending) begin
					irq_q <= 1'b1;
					cur_q <= pick;
				end
			end else if (irq_ack_i) begin
				irq_q        <= 1'b0;
				rdy_q[cur_q] <= 1'b1;
				last_q       <= cur_q;
			end
			if (wr_en)
				en_q <= s_data_i[`SOC_INT_SRC_COUNT-1:0];
		end
	end

	always_comb begin
		case (s_addr_i)
			'd0:     s_data_o = {{(`SOC_ARCH_BITS-1){1'b0}}, last_q};
			'd1:     s_data_o = {{PAD{1'b0}}, en_q};
			default: s_data_o = '0;
		endcase
	end

	assign src_rdy_o = rdy_q;
	assign irq_o     = irq_q;

	a_rdy_onehot: assert property (@(posedge clk100mhz) $onehot0(src_rdy_o));

endmodule

// ==== src/soc_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single bus master; ext_irq_i is a level request acknowledged through irq_ack_i.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "soc_macros.svh"

module soc_top
	import soc_pkg::*;
(
	input  logic                       clk100mhz,
	input  logic                       rst_p,
	input  pi1_op_t                    m_op_i,
	input  logic [`SOC_ADDR_BITS-1:0]  m_addr_i,
	input  logic [`SOC_ARCH_BITS-1:0]  m_data_i,
	input  logic [`SOC_SEL_BITS-1:0]   m_sel_i,
	output logic [`SOC_ARCH_BITS-1:0]  m_data_o,
	output logic                       m_rdy_o,
	input  logic [`SOC_GPIO_COUNT-1:0] gp_i,
	output logic [`SOC_GPIO_COUNT-1:0] gp_o,
	input  logic                       ext_irq_i,
	output logic                       irq_o,
	input  logic                       irq_ack_i,
	output logic                       sys_rst_o
);

	logic                          sys_rst;
	rst_cmd_t                      rst_cmd;
	pi1_op_t                       s_op [`SOC_DEV_COUNT];
	logic [`SOC_SLOT_SHIFT-1:0]    s_addr;
	logic [`SOC_ARCH_BITS-1:0]     s_wdata;
	logic [`SOC_SEL_BITS-1:0]      s_sel;
	logic [`SOC_ARCH_BITS-1:0]     s_rdata [`SOC_DEV_COUNT];
	logic [`SOC_DEV_COUNT-1:0]     s_rdy;
	logic [`SOC_INT_SRC_COUNT-1:0] int_req;
	logic [`SOC_INT_SRC_COUNT-1:0] int_rdy;

	// the external request is masked while its rdy pulses.
	assign int_req[int_src_ext] = ext_irq_i & ~int_rdy[int_src_ext];
	assign sys_rst_o            = sys_rst;

	reset_seq i_reset_seq (
		.clk100mhz (clk100mhz),
		.rst_p     (rst_p),
		.rst_cmd_i (rst_cmd),
		.sys_rst_o (sys_rst)
	);

	pi1_router i_pi1_router (
		.clk100mhz (clk100mhz), .sys_rst_i (sys_rst),
		.m_op_i    (m_op_i),    .m_addr_i  (m_addr_i), .m_data_i (m_data_i),
		.m_sel_i   (m_sel_i),   .m_data_o  (m_data_o), .m_rdy_o  (m_rdy_o),
		.s_op_o    (s_op),      .s_addr_o  (s_addr),   .s_data_o (s_wdata),
		.s_sel_o   (s_sel),     .s_data_i  (s_rdata),  .s_rdy_i  (s_rdy)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	dev_table i_dev_table (
		.clk100mhz (clk100mhz),             .sys_rst_i (sys_rst),
		.s_op_i    (s_op[slot_devtbl]),     .s_addr_i  (s_addr),
		.s_data_i  (s_wdata),               .s_sel_i   (s_sel),
		.s_data_o  (s_rdata[slot_devtbl]),  .s_rdy_o   (s_rdy[slot_devtbl]),
		.rst_cmd_o (rst_cmd)
	);

	gpio_port i_gpio_port (
		.clk100mhz (clk100mhz),             .sys_rst_i (sys_rst),
		.s_op_i    (s_op[slot_gpio]),       .s_addr_i  (s_addr),
		.s_data_i  (s_wdata),               .s_sel_i   (s_sel),
		.s_data_o  (s_rdata[slot_gpio]),    .s_rdy_o   (s_rdy[slot_gpio]),
		.gp_i      (gp_i),                  .gp_o      (gp_o),
		.int_req_o (int_req[int_src_gpio]), .int_rdy_i (int_rdy[int_src_gpio])
	);

	int_ctrl i_int_ctrl (
		.clk100mhz (clk100mhz),             .sys_rst_i (sys_rst),
		.s_op_i    (s_op[slot_intctrl]),    .s_addr_i  (s_addr),
		.s_data_i  (s_wdata),               .s_sel_i   (s_sel),
		.s_data_o  (s_rdata[slot_intctrl]), .s_rdy_o   (s_rdy[slot_intctrl]),
		.src_req_i (int_req),               .src_rdy_o (int_rdy),
		.irq_o     (irq_o),                 .irq_ack_i (irq_ack_i)
	);

endmodule

// ==== sim/soc_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// samples DUT outputs on the rising edge; expected values come from tb_soc.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "soc_macros.svh"

module soc_checker (
	input  logic                       clk100mhz,
	input  logic                       rst_p,
	input  logic                       sys_rst_i,
	input  logic                       m_rdy_i,
	input  logic [`SOC_ARCH_BITS-1:0]  m_data_i,
	input  logic [`SOC_GPIO_COUNT-1:0] gp_i,
	input  logic                       irq_i,
	input  logic                       data_chk_i,
	input  logic [`SOC_ARCH_BITS-1:0]  exp_data_i,
	input  logic                       irq_chk_i,
	input  logic                       exp_irq_i,
	input  logic                       rst_chk_i,
	input  logic                       exp_rst_i,
	input  logic                       gp_chk_i,
	input  logic [`SOC_GPIO_COUNT-1:0] exp_gp_i,
	output int                         err_count_o,
	output int                         check_count_o
);

	// the edge that starts the stretch plus 15 counted cycles.
	localparam int STRETCH = 1 << `SOC_RST_CNTR_BITS;

	int   run_len;
	logic rst_seen;

	initial begin
		err_count_o   = 0;
		check_count_o = 0;
		run_len       = 0;
		rst_seen      = 1'b0;
	end

	always @(posedge clk100mhz) begin
		if (data_chk_i && m_rdy_i) begin
			check_count_o++;
			if (m_data_i !== exp_data_i) begin
				err_count_o++;
				$display("FAILED %0t: read data %h, expected %h", $time, m_data_i, exp_data_i);
			end
		end
		if (irq_chk_i) begin
			check_count_o++;
			if (irq_i !== exp_irq_i) begin
				err_count_o++;
				$display("FAILED %0t: irq_o %b, expected %b", $time, irq_i, exp_irq_i);
			end
		end
		if (rst_chk_i) begin
			check_count_o++;
			if (sys_rst_i !== exp_rst_i) begin
				err_count_o++;
				$display("FAILED %0t: sys_rst_o %b, expected %b", $time, sys_rst_i, exp_rst_i);
			end
		end
		if (gp_chk_i) begin
			check_count_o++;
			if (gp_i !== exp_gp_i) begin
				err_count_o++;
				$display("FAILED %0t: gp_o %h, expected %h", $time, gp_i, exp_gp_i);
			end
		end
		// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
		if (rst_seen) begin
			if ((m_rdy_i !== 1'b0) || (irq_i !== 1'b0) || (gp_i !== '0)) begin
				err_count_o++;
				$display("FAILED %0t: outputs not low in reset (rdy %b irq %b gp %h)",
					$time, m_rdy_i, irq_i, gp_i);
			end
		end
		if (rst_p) begin
			run_len = 0;
		end else if (sys_rst_i) begin
			run_len++;
		end else if (run_len != 0) begin
			check_count_o++;
			if (run_len != STRETCH) begin
				err_count_o++;
				$display("FAILED %0t: reset stretch %0d edges, expected %0d",
					$time, run_len, STRETCH);
			end
			run_len = 0;
		end
		rst_seen = sys_rst_i; // flops are reset one edge later.
	end

endmodule

// ==== sim/tb_soc.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// inputs change on the falling edge; soc_checker does all comparing.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "soc_macros.svh"

module tb_soc
	import soc_pkg::*;
;

	localparam logic [1:0] K_CHK  = 2'd0; // compare with rdata.
	localparam logic [1:0] K_NONE = 2'd1;
	localparam logic [1:0] K_RW   = 2'd2; // expect low byte of last random write.

	localparam logic [`SOC_ADDR_BITS-1:0] GPIO_OUT_ADDR = 30'h401;

	typedef struct packed {
		pi1_op_t                    op;
		logic [`SOC_ADDR_BITS-1:0]  addr;
		logic [`SOC_ARCH_BITS-1:0]  wdata;
		logic [`SOC_ARCH_BITS-1:0]  rdata;
		logic [1:0]                 kind;
		logic [`SOC_GPIO_COUNT-1:0] gp;
		logic                       ext;
		logic                       irq;
		logic                       ack;
	} step_t;

	logic                       clk100mhz = 1'b0;
	logic                       rst_p;
	pi1_op_t                    m_op_i;
	logic [`SOC_ADDR_BITS-1:0]  m_addr_i;
	logic [`SOC_ARCH_BITS-1:0]  m_data_i;
	logic [`SOC_SEL_BITS-1:0]   m_sel_i;
	logic [`SOC_ARCH_BITS-1:0]  m_data_o;
	logic                       m_rdy_o;
	logic [`SOC_GPIO_COUNT-1:0] gp_i;
	logic [`SOC_GPIO_COUNT-1:0] gp_o;
	logic                       ext_irq_i;
	logic                       irq_o;
	logic                       irq_ack_i;
	logic                       sys_rst_o;
	logic                       data_chk;
	logic                       irq_chk;
	logic                       rst_chk;
	logic                       gp_chk;
	logic [`SOC_ARCH_BITS-1:0]  exp_data;
	logic                       exp_irq;
	logic                       exp_rst;
	logic [`SOC_GPIO_COUNT-1:0] exp_gp;
	int                         err_count;
	int                         check_count;
	integer                     seed = 32'h47efadd0;
	logic [`SOC_ARCH_BITS-1:0]  last_rw;
	step_t                      steps [$];
	logic                       table_ready = 1'b0;

	always #5 clk100mhz = ~clk100mhz;

	soc_checker i_soc_checker (
		.clk100mhz   (clk100mhz), .rst_p      (rst_p),    .sys_rst_i  (sys_rst_o),
		.m_rdy_i     (m_rdy_o),   .m_data_i   (m_data_o), .gp_i       (gp_o),
		.irq_i       (irq_o),     .data_chk_i (data_chk), .exp_data_i (exp_data),
		.irq_chk_i   (irq_chk),   .exp_irq_i  (exp_irq),  .rst_chk_i  (rst_chk),
		.exp_rst_i   (exp_rst),   .gp_chk_i   (gp_chk),   .exp_gp_i   (exp_gp),
		.err_count_o (err_count), .check_count_o (check_count)
	);

	soc_top i_soc_top (
		.clk100mhz (clk100mhz), .rst_p     (rst_p),     .m_op_i   (m_op_i),
		.m_addr_i  (m_addr_i),  .m_data_i  (m_data_i),  .m_sel_i  (m_sel_i),
		.m_data_o  (m_data_o),  .m_rdy_o   (m_rdy_o),   .gp_i     (gp_i),
		.gp_o      (gp_o),      .ext_irq_i (ext_irq_i), .irq_o    (irq_o),
		.irq_ack_i (irq_ack_i), .sys_rst_o (sys_rst_o)
	);

	task automatic add_step(input pi1_op_t op, input logic [29:0] addr, input logic [31:0] wdata,
		input logic [31:0] rdata, input logic [1:0] kind, input logic [7:0] gp,
		input logic ext, input logic irq, input logic ack);
		steps.push_back({op, addr, wdata, rdata, kind, gp, ext, irq, ack});
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic build_table();
		add_step(pi1_rdop, 30'h000, 0, 32'h3,        K_CHK,  8'h00, 0, 0, 0);
		add_step(pi1_rdop, 30'h001, 0, 32'h0000_0400, K_CHK,  8'h00, 0, 0, 0);
		add_step(pi1_rdop, 30'h002, 0, 32'h0001_0400, K_CHK,  8'h00, 0, 0, 0);
		add_step(pi1_rdop, 30'h003, 0, 32'h0002_0400, K_CHK,  8'h00, 0, 0, 0);
		add_step(pi1_wrop, 30'h401, 32'hA5, 0,        K_NONE, 8'h00, 0, 0, 0);
		add_step(pi1_rdop, 30'h401, 0, 32'hA5,        K_CHK,  8'h00, 0, 0, 0);
		add_step(pi1_rwop, 30'h401, 0, 32'hA5,        K_CHK,  8'h00, 0, 0, 0);
		add_step(pi1_rdop, 30'h401, 0, 0,             K_RW,   8'h00, 0, 0, 0);
		add_step(pi1_rdop, 30'h400, 0, 32'h3C,        K_CHK,  8'h3C, 0, 0, 0);
		add_step(pi1_wrop, 30'h402, 32'h01, 0,        K_NONE, 8'h3C, 0, 0, 0);
		add_step(pi1_wrop, 30'hC05, 32'hDEADBEEF, 0,  K_CHK,  8'h3C, 0, 0, 0);
		add_step(pi1_rdop, 30'hC05, 0, 0,             K_CHK,  8'h3C, 0, 0, 0);
		add_step(pi1_rdop, 30'h1000, 0, 0,            K_CHK,  8'h3C, 0, 0, 0);
		add_step(pi1_rdop, 30'h800, 0, int_src_gpio,  K_CHK,  8'h3D, 0, 1, 1);
		add_step(pi1_rdop, 30'h800, 0, int_src_ext,   K_CHK,  8'h3D, 1, 1, 1);
		add_step(pi1_wrop, 30'h801, 32'h2, 0,         K_NONE, 8'h3D, 0, 0, 0);
		add_step(pi1_rdop, 30'h801, 0, 32'h2,         K_CHK,  8'h3C, 0, 0, 0);
		add_step(pi1_wrop, 30'h000, rst_warm, 0,      K_NONE, 8'h3C, 0, 0, 0);
		add_step(pi1_rdop, 30'h401, 0, 0,             K_CHK,  8'h3C, 0, 0, 0);
	endtask

	task automatic transfer(input pi1_op_t op, input logic [29:0] addr,
		input logic [31:0] wdata, input logic [31:0] exp, input logic chk);
		@(negedge clk100mhz);
		m_op_i   = op;
		m_addr_i = addr;
		m_data_i = wdata;
		exp_data = exp;
		data_chk = chk;
		do @(negedge clk100mhz); while (!m_rdy_o);
		m_op_i = pi1_noop;
		@(negedge clk100mhz); // checker samples m_rdy_o before this edge.
		data_chk = 1'b0;
	endtask

	task automatic run_step(input step_t s);
		logic [31:0] wdata;
		logic [31:0] exp;
		wdata = s.wdata;
		exp   = s.rdata;
		@(negedge clk100mhz);
		gp_i      = s.gp;
		ext_irq_i = s.ext;
		repeat (6) @(negedge clk100mhz); // covers synchronizer and irq latency.
		irq_chk = 1'b1;
		exp_irq = s.irq;
		@(negedge clk100mhz);
		irq_chk = 1'b0;
		if (s.ack) begin
			irq_ack_i = 1'b1;
			@(negedge clk100mhz);
			irq_ack_i = 1'b0;
			ext_irq_i = 1'b0; // source drops req on its rdy pulse.
		end
		if (s.op == pi1_rwop) begin
			wdata   = $random(seed);
			last_rw = wdata;
		end
		if (s.kind == K_RW)
			exp = {24'h0, last_rw[7:0]};
		if ((s.addr == GPIO_OUT_ADDR) && (s.kind != K_NONE)) begin
			gp_chk = 1'b1; // the output register drives gp_o.
			exp_gp = exp[`SOC_GPIO_COUNT-1:0];
			@(negedge clk100mhz);
			gp_chk = 1'b0;
		end
		transfer(s.op, s.addr, wdata, exp, s.kind != K_NONE);
	endtask

	task automatic pulse_rst_p();
		@(negedge clk100mhz);
		rst_p = 1'b1;
		repeat (8) @(negedge clk100mhz);
		rst_p = 1'b0;
		while (sys_rst_o)
			@(negedge clk100mhz);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		m_op_i    = pi1_noop;
		m_addr_i  = '0;
		m_data_i  = '0;
		m_sel_i   = '1;
		gp_i      = '0;
		ext_irq_i = 1'b0;
		irq_ack_i = 1'b0;
		data_chk  = 1'b0;
		irq_chk   = 1'b0;
		rst_chk   = 1'b0;
		gp_chk    = 1'b0;
		exp_data  = '0;
		exp_irq   = 1'b0;
		exp_rst   = 1'b0;
		exp_gp    = '0;
		last_rw   = '0;
		rst_p     = 1'b1;
		build_table();
		table_ready = 1'b1;
		repeat (8) @(negedge clk100mhz);
		rst_p = 1'b0;
		while (sys_rst_o)
			@(negedge clk100mhz);
		for (int i = 0; i < steps.size(); i++)
			run_step(steps[i]);
		// power-off holds reset until rst_p.
		transfer(pi1_wrop, 30'h000, rst_poweroff, 0, 1'b0);
		repeat (30) @(negedge clk100mhz);
		rst_chk = 1'b1;
		exp_rst = 1'b1;
		@(negedge clk100mhz);
		rst_chk = 1'b0;
		pulse_rst_p();
		transfer(pi1_rdop, 30'h000, 0, 32'h3, 1'b1);
		repeat (3) @(negedge clk100mhz);
		$display("errors %0d of %0d checks", err_count, check_count);
		if (err_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	initial begin
		wait (table_ready);
		repeat (steps.size() * 50 + 200) @(posedge clk100mhz);
		$display("timeout: the DUT stopped answering, %0d errors so far", err_count);
		$display("sim failed");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+include
src/soc_pkg.sv
src/reset_seq.sv
src/pi1_router.sv
src/dev_table.sv
src/gpio_port.sv
src/int_ctrl.sv
src/soc_top.sv
sim/soc_checker.sv
sim/tb_soc.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Iinclude -f project.f \
	--top-module tb_soc -Mdir obj_dir -o tb_soc
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/tb_soc)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
	exit 0
fi
exit 1
